//--- run.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f vlog.f --top-module intc_tb -o intc_sim \
    > build.log 2>&1 \
    && ./obj_dir/intc_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null && echo "RUN OK" && exit 0 \
    || { echo "RUN FAILED"; exit 1; }

//--- verification/intc_tb.sv
// Table-driven testbench for intc_top that emulates the processor handshake and checks every vector.
`timescale 1ns/1ps
`default_nettype none

module intc_tb import intc_pkg::*; ();

    localparam int NUM_ROWS = 6;            // Scenarios in the table.

    // One scenario, words[7:0] is the first table word on the bus.
    typedef struct packed {
        logic        prio;                  // 1 for priority mode, 0 for polling.
        logic [31:0] words;                 // Four table load words.
        logic [7:0]  rq;                    // Request lines held during the row.
        int          nserv;                 // Services, the last one ends with a bad done word.
    } row_t;

    logic        clk_in;
    logic        rst_in;
    logic [7:0]  intr_rq;
    logic [7:0]  bus_in;
    logic        ack_n;
    logic [7:0]  bus_out;
    logic        bus_oe;
    logic        intr_out;

    logic [15:0] lfsr_state;                // Random source for tables and patterns.
    row_t        rows [NUM_ROWS];

    intc_top u_intc_top (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .intr_rq  (intr_rq),
        .bus_in   (bus_in),
        .ack_n    (ack_n),
        .bus_out  (bus_out),
        .bus_oe   (bus_oe),
        .intr_out (intr_out)
    );

    // 4 ns clock.
    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // Galois LFSR, one step per bit taken, newest bit at the bottom.
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        logic       lsb;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            v          = {v[6:0], lsb};
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 16'hB400;   // x^16+x^14+x^13+x^11+1.
        end
        return v;
    endfunction

    // Polling model: next active line after the one served last.
    function automatic logic [2:0] next_poll_id(input logic [7:0] rq, input logic [2:0] last);
        logic [2:0] i;
        i = last;
        for (int k = 0; k < 8; k++) begin
            i = i + 3'd1;
            if (rq[i]) return i;
        end
        return last;
    endfunction

    // Priority model: first table entry whose line is active.
    function automatic logic [2:0] first_active_entry(input logic [31:0] words,
                                                      input logic [7:0]  rq);
        logic [31:0] w;
        logic [2:0]  hi;
        logic [2:0]  lo;
        w = words;
        for (int k = 0; k < 4; k++) begin
            hi = w[7:5];                    // Higher ranked entry of the pair.
            lo = w[4:2];
            if (rq[hi]) return hi;
            if (rq[lo]) return lo;
            w = w >> 8;
        end
        return 3'd0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s expected %02h actual %02h", name, expected, actual));
        end
    endtask

    // One cycle of ack_n low with a word on the bus, then sample mid cycle.
    task automatic pulse_ack(input logic [7:0] word);
        @(posedge clk_in);
        ack_n  <= 1'b0;
        bus_in <= word;
        @(posedge clk_in);
        ack_n  <= 1'b1;
        bus_in <= 8'h00;                    // Idle bus is no command.
        @(negedge clk_in);
    endtask

    task automatic wait_for_intr(input string name);
        int n;
        n = 0;
        while (intr_out !== 1'b1 && n < 100) begin
            @(negedge clk_in);
            n++;
        end
        if (intr_out !== 1'b1) begin
            abort_run($sformatf("Timed out in %s waiting for intr_out to rise.", name));
        end
    endtask

    // intr_out must stay low while nothing is loaded.
    task automatic quiet_window(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_in);
            check_value($sformatf("%s intr_out", name), 8'h00, {7'd0, intr_out});
            check_value($sformatf("%s bus_oe", name), 8'h00, {7'd0, bus_oe});
        end
    endtask

    // Poll command, or four table words for priority mode.
    task automatic load_mode(input logic prio, input logic [31:0] words);
        logic [31:0] w;
        w = words;
        if (prio) begin
            for (int k = 0; k < 4; k++) begin
                @(posedge clk_in);
                bus_in <= w[7:0];
                w = w >> 8;
            end
        end else begin
            @(posedge clk_in);
            bus_in <= 8'h01;
        end
        @(posedge clk_in);
        bus_in <= 8'h00;
        @(negedge clk_in);
    endtask

    // Full three ack service of one id.
    task automatic serve(input string name, input logic [2:0] id, input logic prio,
                         input logic bad_done);
        logic [7:0] vec;
        logic [7:0] done_word;
        vec       = prio ? {VEC_PRIO, id} : {VEC_POLL, id};
        done_word = prio ? {DONE_PRIO, id} : {DONE_POLL, id};
        if (bad_done) done_word = prio ? {DONE_POLL, id} : {DONE_PRIO, id}; // Wrong code.
        wait_for_intr(name);
        pulse_ack(8'h00);                   // First ack, vector out.
        check_value($sformatf("%s intr_low", name), 8'h00, {7'd0, intr_out});
        check_value($sformatf("%s oe_high", name), 8'h01, {7'd0, bus_oe});
        check_value($sformatf("%s vector", name), vec, bus_out);
        pulse_ack(8'h00);                   // Second ack, bus released.
        check_value($sformatf("%s oe_low", name), 8'h00, {7'd0, bus_oe});
        pulse_ack(done_word);
    endtask

    // Runaway guard.
    initial begin
        repeat (20000) @(posedge clk_in);
        abort_run("Global watchdog expired before the test finished.");
    end

    initial begin
        logic [31:0] words;
        logic [7:0]  tmp;
        logic [2:0]  last;
        logic [2:0]  exp_id;
        rst_in     = 1'b1;
        intr_rq    = 8'h00;
        bus_in     = 8'h00;
        ack_n      = 1'b1;
        lfsr_state = 16'd54377;

        // Scenario table, odd rows in priority mode.
        for (int r = 0; r < NUM_ROWS; r++) begin
            words = 32'h0;
            for (int k = 0; k < 4; k++) begin
                tmp   = lfsr_bits(6);
                words = {tmp[5:0], 2'b10, words[31:8]};     // Shift in from the top.
            end
            tmp           = lfsr_bits(8);
            rows[r].prio  = (r % 2 == 1);
            rows[r].words = words;
            rows[r].nserv = 4 + r;
            if (rows[r].prio) rows[r].rq = tmp | (8'd1 << words[28:26]); // Entry 7 live.
            else rows[r].rq = tmp | 8'h09;  // At least two lines.
        end

        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        check_value("reset intr_out", 8'h00, {7'd0, intr_out});
        check_value("reset bus_oe", 8'h00, {7'd0, bus_oe});
        @(posedge clk_in);
        intr_rq <= 8'hFF;
        quiet_window("no_command", 20);     // Requests alone raise nothing.

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_in);
            intr_rq <= rows[r].rq;
            load_mode(rows[r].prio, rows[r].words);
            last = 3'd7;                    // Scan starts at line 0.
            for (int s = 0; s < rows[r].nserv; s++) begin
                exp_id = rows[r].prio ? first_active_entry(rows[r].words, rows[r].rq)
                                      : next_poll_id(rows[r].rq, last);
                serve($sformatf("row%0d svc%0d", r, s), exp_id, rows[r].prio,
                      s == rows[r].nserv - 1);
                last = exp_id;
            end
            quiet_window($sformatf("row%0d after_err", r), 20);  // Back in command phase.
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/intc_ack_sequencer.sv
// Processor handshake FSM that raises intr_out, sends the vector word and checks the done word.
`timescale 1ns/1ps
`default_nettype none

module intc_ack_sequencer import intc_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    intc_src_if.sink         poll_src,
    intc_src_if.sink         prio_src,
    input  logic             ack_n,         // Active low strobe from the processor.
    input  logic [BUS_W-1:0] bus_in,
    output logic [BUS_W-1:0] bus_out,
    output logic             bus_oe,
    output logic             intr_out,
    output logic             err            // Done word mismatch, single cycle.
);

    intc_seq_state_e   state;
    intc_id_t          cur_id;              // Id being served.
    logic              sel_prio;            // Served request came from the resolver.
    logic              done_q;              // Clean completion strobe.
    logic              ack;
    logic              any_req;
    logic [CODE_W-1:0] vec_code;
    logic [CODE_W-1:0] done_code;
    logic              done_match;

    assign ack     = !ack_n;                // Every low cycle counts as one strobe.
    assign any_req = poll_src.req || prio_src.req;

    // Only one mode is live, so whichever requests gets the grant.
    assign poll_src.grant = (state == SEQ_IDLE) && poll_src.req;
    assign prio_src.grant = (state == SEQ_IDLE) && prio_src.req;

    // Completion goes back to the source that was served.
    assign poll_src.done = done_q && !sel_prio;
    assign prio_src.done = done_q && sel_prio;

    assign vec_code   = sel_prio ? VEC_PRIO : VEC_POLL;
    assign done_code  = sel_prio ? DONE_PRIO : DONE_POLL;
    assign done_match = (bus_in == {done_code, cur_id});

    // Handshake control.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state    <= SEQ_IDLE;
            intr_out <= 1'b0;
            bus_oe   <= 1'b0;
            done_q   <= 1'b0;
            err      <= 1'b0;
        end else begin
            done_q <= 1'b0;                     // Strobes last one cycle.
            err    <= 1'b0;
            unique case (state)
                SEQ_IDLE: begin
                    if (any_req) begin
                        intr_out <= 1'b1;       // Interrupt the processor.
                        state    <= SEQ_WAIT_ACK;
                    end
                end
                SEQ_WAIT_ACK: begin
                    if (ack) begin
                        intr_out <= 1'b0;
                        bus_oe   <= 1'b1;       // Vector goes out.
                        state    <= SEQ_SEND_VEC;
                    end
                end
                SEQ_SEND_VEC: begin
                    if (ack) begin
                        bus_oe <= 1'b0;         // Release the bus for the done word.
                        state  <= SEQ_WAIT_DONE;
                    end
                end
                SEQ_WAIT_DONE: begin
                    if (ack) begin
                        done_q <= done_match;
                        err    <= !done_match;  // Any mismatch is an error.
                        state  <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // Served id and origin, captured on grant.
    always_ff @(posedge clk_in) begin
        if (state == SEQ_IDLE && any_req) begin
            sel_prio <= prio_src.req;
            cur_id   <= prio_src.req ? prio_src.id : poll_src.id;
        end
    end

    // Vector word, code in bits 7:3 and id below.
    always_ff @(posedge clk_in) begin
        if (state == SEQ_WAIT_ACK && ack) begin
            bus_out <= {vec_code, cur_id};
        end
    end

    // Scanner and resolver are never active together.
    a_one_source: assert property (@(posedge clk_in) disable iff (rst_in)
        !(poll_src.req && prio_src.req))
        else $error("Poll and priority sources requested together.");

endmodule

`default_nettype wire

//--- verilog/intc_cmd_decoder.sv
// Command phase decoder that selects the operating mode and loads the priority table from the bus.
`timescale 1ns/1ps
`default_nettype none

module intc_cmd_decoder import intc_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic [BUS_W-1:0] bus_in,        // Command words from the processor.
    input  logic             err,           // Done word mismatch from the sequencer.
    output intc_mode_e       mode,
    output intc_table_t      prio_table
);

    intc_cmd_e         cmd;                 // Command field of the current word.
    logic [WCNT_W-1:0] word_cnt;            // Table words received so far.
    logic              last_word;           // This CMD_PRIO word completes the table.
    logic              load_word;           // Write two table entries this cycle.

    assign cmd       = intc_cmd_e'(bus_in[1:0]);
    assign last_word = (word_cnt == WCNT_W'(TABLE_WORDS - 1));
    assign load_word = (mode == MODE_CMD) && (cmd == CMD_PRIO);

    // Mode register and word counter.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            mode     <= MODE_CMD;
            word_cnt <= '0;
        end else if (err) begin
            mode     <= MODE_CMD;               // Bad done word returns to commands.
            word_cnt <= '0;
        end else if (mode == MODE_CMD) begin
            case (cmd)
                CMD_POLL: begin
                    mode     <= MODE_POLL;      // Polling from the next cycle.
                    word_cnt <= '0;
                end
                CMD_PRIO: begin
                    if (last_word) begin
                        mode     <= MODE_PRIO;  // Table complete.
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: word_cnt <= '0;        // Broken sequence restarts the load.
            endcase
        end
    end

    // Two entries per word with the higher priority in bits 7:5.
    always_ff @(posedge clk_in) begin
        if (load_word) begin
            prio_table[(2 * word_cnt) * ID_W +: ID_W]     <= bus_in[BUS_W-1 -: ID_W];
            prio_table[(2 * word_cnt + 1) * ID_W +: ID_W] <= bus_in[BUS_W-1-ID_W -: ID_W];
        end
    end

    // Polling needs a poll word on the bus, priority mode four table words in a row.
    a_mode_exit: assert property (@(posedge clk_in) disable iff (rst_in)
        ($past(mode) == MODE_CMD && mode != MODE_CMD) |->
            ((mode == MODE_POLL && $past(bus_in[1:0]) == CMD_POLL) ||
             (mode == MODE_PRIO &&
              $past(bus_in[1:0], 1) == CMD_PRIO &&
              $past(bus_in[1:0], 2) == CMD_PRIO &&
              $past(bus_in[1:0], 3) == CMD_PRIO &&
              $past(bus_in[1:0], 4) == CMD_PRIO)))
        else $error("Mode left MODE_CMD without a valid command.");

endmodule

`default_nettype wire

//--- verilog/intc_pkg.sv
// Widths, bus codes and enum types of the interrupt controller, imported by each module header.
`default_nettype none

package intc_pkg;

    // Sizes of the request side and of the processor bus.
    localparam int NUM_SRC     = 8;                     // Interrupt request lines.
    localparam int ID_W        = 3;                     // Source id width.
    localparam int BUS_W       = 8;                     // Data bus width.
    localparam int CODE_W      = 5;                     // Code field in bits 7:3.
    localparam int TABLE_WORDS = 4;                     // Command words per table load.
    localparam int WCNT_W      = $clog2(TABLE_WORDS);   // Table word counter width.

    // Codes sent by the controller in the vector word.
    localparam logic [CODE_W-1:0] VEC_POLL  = 5'b01011;
    localparam logic [CODE_W-1:0] VEC_PRIO  = 5'b10011;

    // Codes the processor returns in the done word.
    localparam logic [CODE_W-1:0] DONE_POLL = 5'b10100;
    localparam logic [CODE_W-1:0] DONE_PRIO = 5'b01100;

    typedef logic [ID_W-1:0] intc_id_t;                 // One source id.

    // Entry i sits at bits [i*ID_W +: ID_W], entry 0 is served first.
    typedef logic [NUM_SRC*ID_W-1:0] intc_table_t;

    // Operating mode of the controller.
    typedef enum logic [1:0] {
        MODE_CMD,                                       // Waiting for commands.
        MODE_POLL,                                      // Rotating scan.
        MODE_PRIO                                       // Table ordered search.
    } intc_mode_e;

    // Command field in bits 1:0 of a command word.
    typedef enum logic [1:0] {
        CMD_POLL = 2'b01,
        CMD_PRIO = 2'b10
    } intc_cmd_e;

    // Processor handshake states.
    typedef enum logic [1:0] {
        SEQ_IDLE,                                       // Waiting for a source request.
        SEQ_WAIT_ACK,                                   // intr_out high, first ack pending.
        SEQ_SEND_VEC,                                   // Vector on the bus, second ack pending.
        SEQ_WAIT_DONE                                   // Service running, done word pending.
    } intc_seq_state_e;

endpackage

`default_nettype wire

//--- verilog/intc_poll_scanner.sv
// Polling mode source selector that checks one request line per cycle in rotating order.
`timescale 1ns/1ps
`default_nettype none

module intc_poll_scanner import intc_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  intc_mode_e         mode,
    input  logic [NUM_SRC-1:0] intr_rq,
    intc_src_if.source         src
);

    intc_id_t idx;          // Line under inspection.
    logic     in_flight;    // Granted and waiting for done.
    logic     idle;         // Free to look at the next line.

    assign idle   = !src.req && !in_flight;
    assign src.id = idx;                        // Index holds still until done.

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            idx       <= '0;
            in_flight <= 1'b0;
            src.req   <= 1'b0;
        end else if (mode != MODE_POLL) begin
            idx       <= '0;                    // Restart at line 0 next time.
            in_flight <= 1'b0;
            src.req   <= 1'b0;
        end else begin
            if (src.grant) begin
                src.req   <= 1'b0;              // Drop the request after grant.
                in_flight <= 1'b1;
            end
            if (src.done) begin
                in_flight <= 1'b0;
                idx       <= idx + 1'b1;        // Move past the served line.
            end
            if (idle) begin
                if (intr_rq[idx]) begin
                    src.req <= 1'b1;            // Found one and stay on it.
                end else begin
                    idx <= idx + 1'b1;          // Nothing here so try the next line.
                end
            end
        end
    end

    // A done strobe from the sequencer closes the service this scanner has outstanding.
    a_done_in_flight: assert property (@(posedge clk_in) disable iff (rst_in)
        src.done |-> in_flight)
        else $error("Poll done arrived with no service outstanding.");

endmodule

`default_nettype wire

//--- verilog/intc_prio_resolver.sv
// Priority mode source selector that picks the first active line in table order.
`timescale 1ns/1ps
`default_nettype none

module intc_prio_resolver import intc_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  intc_mode_e         mode,
    input  intc_table_t        prio_table,
    input  logic [NUM_SRC-1:0] intr_rq,
    intc_src_if.source         src
);

    logic     in_flight;    // Granted and waiting for done.
    logic     idle;         // Free to search.
    logic     hit;          // Some table entry is active.
    intc_id_t hit_id;       // Id of the best active entry.

    assign idle = !src.req && !in_flight;

    // Walk from the lowest entry up so entry 0 wins last.
    always_comb begin
        hit    = 1'b0;
        hit_id = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (intr_rq[prio_table[i*ID_W +: ID_W]]) begin
                hit    = 1'b1;
                hit_id = prio_table[i*ID_W +: ID_W];
            end
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            in_flight <= 1'b0;
            src.req   <= 1'b0;
        end else if (mode != MODE_PRIO) begin
            in_flight <= 1'b0;                  // Inactive outside priority mode.
            src.req   <= 1'b0;
        end else begin
            if (src.grant) begin
                src.req   <= 1'b0;
                in_flight <= 1'b1;
            end
            if (src.done) begin
                in_flight <= 1'b0;              // Search again next cycle.
            end
            if (idle && hit) begin
                src.req <= 1'b1;
            end
        end
    end

    // Winner is captured with req so later line changes do not disturb it.
    always_ff @(posedge clk_in) begin
        if (idle && hit) begin
            src.id <= hit_id;
        end
    end

endmodule

`default_nettype wire

//--- verilog/intc_src_if.sv
// Request link from one source selector to the ack sequencer, instantiated once per mode.
`timescale 1ns/1ps
`default_nettype none

interface intc_src_if import intc_pkg::*; ();

    logic     req;      // Source has a candidate, held until grant.
    intc_id_t id;       // Candidate id, stable while req is high.
    logic     grant;    // Single cycle, request accepted.
    logic     done;     // Single cycle, service finished cleanly.

    // Selector side.
    modport source (
        output req,
        output id,
        input  grant,
        input  done
    );

    // Sequencer side.
    modport sink (
        input  req,
        input  id,
        output grant,
        output done
    );

endinterface

`default_nettype wire

//--- verilog/intc_top.sv
// Top level of the eight line interrupt controller with separate bus input and output ports.
`timescale 1ns/1ps
`default_nettype none

module intc_top import intc_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic [NUM_SRC-1:0] intr_rq,     // Request lines.
    input  logic [BUS_W-1:0]   bus_in,      // Commands and done words.
    input  logic               ack_n,       // Processor acknowledge, active low.
    output logic [BUS_W-1:0]   bus_out,     // Vector word.
    output logic               bus_oe,      // bus_out is valid.
    output logic               intr_out     // Interrupt to the processor.
);

    intc_mode_e  mode;
    intc_table_t prio_table;
    logic        err;

    intc_src_if poll_if ();                 // Scanner to sequencer.
    intc_src_if prio_if ();                 // Resolver to sequencer.

    intc_cmd_decoder u_cmd_decoder (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .bus_in     (bus_in),
        .err        (err),
        .mode       (mode),
        .prio_table (prio_table)
    );

    intc_poll_scanner u_poll_scanner (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .mode    (mode),
        .intr_rq (intr_rq),
        .src     (poll_if)
    );

    intc_prio_resolver u_prio_resolver (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .mode       (mode),
        .prio_table (prio_table),
        .intr_rq    (intr_rq),
        .src        (prio_if)
    );

    intc_ack_sequencer u_ack_sequencer (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .poll_src (poll_if),
        .prio_src (prio_if),
        .ack_n    (ack_n),
        .bus_in   (bus_in),
        .bus_out  (bus_out),
        .bus_oe   (bus_oe),
        .intr_out (intr_out),
        .err      (err)
    );

endmodule

`default_nettype wire

//--- vlog.f
verilog/intc_pkg.sv
verilog/intc_src_if.sv
verilog/intc_cmd_decoder.sv
verilog/intc_poll_scanner.sv
verilog/intc_prio_resolver.sv
verilog/intc_ack_sequencer.sv
verilog/intc_top.sv
verification/intc_tb.sv
